//--- src/fp128_pkg.sv
// ========================================================================
// binary128 operand format
// ========================================================================

package fp128_pkg;

	// field boundaries of a quad precision word
	// exponent is 15 bits, mantissa 112 bits, plus the sign
	localparam int EMSB = 14;
	localparam int FMSB = 111;

	// total word width, sign + exponent + mantissa
	localparam int FP128_W = 1 + (EMSB + 1) + (FMSB + 1);

	// exponent value shared by infinity and NaN
	localparam logic [EMSB:0] EXP_ONES = '1;

	// field view of one operand, msb first
	typedef struct packed {
		logic            sign;
		logic [EMSB:0]   exp;
		logic [FMSB:0]   man;
	} fp128_fields_t;

	// one operand seen two ways
	// raw for equality tests and transport
	// fields for the decomposer
	typedef union packed {
		logic [FP128_W-1:0] raw;
		fp128_fields_t      fields;
	} fp128_t;

endpackage

//--- src/fcmp_pkg.sv
// ========================================================================
// comparison result layout and lane count
// ========================================================================

package fcmp_pkg;

	// number of parallel lanes, power of two
	localparam int NUM_LANES = 4;

	// lane index width, kept at least one bit wide
	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	// predicate word
	localparam int PRED_W = 16;
	typedef logic [PRED_W-1:0] fcmp_pred_t;

	// lower byte, the "true" predicates
	localparam int P_EQ  = 0;
	localparam int P_LT  = 1;
	localparam int P_LE  = 2;
	localparam int P_MLT = 3;
	localparam int P_UN  = 4;

	// upper byte, their complements
	// bits 7:5 and 15:13 are always zero
	localparam int P_NE  = 8;
	localparam int P_GE  = 9;
	localparam int P_GT  = 10;
	localparam int P_MGE = 11;
	localparam int P_OR  = 12;

endpackage

//--- src/fp128_decomp.sv
// splits a quad precision operand into its fields
// and classifies the special values
module fp128_decomp
(
	input  fp128_pkg::fp128_t          i,
	output logic                       sgn,
	output logic [fp128_pkg::EMSB:0]   exp,
	output logic [fp128_pkg::FMSB:0]   man,
	output logic                       vz,
	output logic                       inf,
	output logic                       qnan,
	output logic                       snan,
	output logic                       nan
);

	import fp128_pkg::*;

	// exponent at its maximum, inf or nan
	logic exp_max;
	// mantissa all zero
	logic man_zero;

	// plain field extraction
	assign sgn = i.fields.sign;
	assign exp = i.fields.exp;
	assign man = i.fields.man;

	assign exp_max  = (i.fields.exp == EXP_ONES);
	assign man_zero = (i.fields.man == '0);

	// zero of either sign, denormals are not zero
	assign vz = (i.fields.exp == '0) && man_zero;

	// all ones exponent, split on the mantissa
	assign inf = exp_max && man_zero;
	assign nan = exp_max && !man_zero;

	// top mantissa bit set means quiet
	assign qnan = nan && i.fields.man[FMSB];
	assign snan = nan && !i.fields.man[FMSB];

endmodule

//--- src/fcmp_lane.sv
// one comparison lane
// combinational compare feeding a single entry output register
module fcmp_lane
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  fp128_pkg::fp128_t      a,
	input  fp128_pkg::fp128_t      b,
	output logic                   out_valid,
	input  logic                   out_ready,
	output fcmp_pkg::fcmp_pred_t   pred,
	output logic                   nan,
	output logic                   snan
);

	import fp128_pkg::*;
	import fcmp_pkg::*;

	// decomposed operands
	logic            sa, sb;
	logic [EMSB:0]   xa, xb;
	logic [FMSB:0]   ma, mb;
	logic            az, bz;
	logic            inf_a, inf_b;
	logic            nan_a, nan_b;
	logic            snan_a, snan_b;

	// compare terms
	logic            unordered;
	logic            same_val;
	logic            eq;
	logic            mag_lt;
	logic            mag_gt;
	logic            lt;

	// next register contents
	fcmp_pred_t      pred_d;
	logic            nan_d;
	logic            snan_d;

	// output register
	logic            valid_q;
	fcmp_pred_t      pred_q;
	logic            nan_q;
	logic            snan_q;

	fp128_decomp u_dec_a (.i(a), .sgn(sa), .exp(xa), .man(ma), .vz(az), .inf(inf_a),
		.qnan(), .snan(snan_a), .nan(nan_a));
	fp128_decomp u_dec_b (.i(b), .sgn(sb), .exp(xb), .man(mb), .vz(bz), .inf(inf_b),
		.qnan(), .snan(snan_b), .nan(nan_b));

	// ====================================================================
	// compare
	// ====================================================================

	assign unordered = nan_a | nan_b;

	// +0 and -0 are the same value
	assign same_val = (az & bz) | (a.raw == b.raw);
	assign eq       = same_val & !unordered;

	// magnitude only, sign ignored
	assign mag_lt = {xa, ma} < {xb, mb};
	assign mag_gt = {xa, ma} > {xb, mb};

	// differing signs, the negative one is less unless both are zero
	// same signs, magnitude order flips for negatives
	assign lt = (sa ^ sb) ? (sa & !(az & bz)) : (sa ? mag_gt : mag_lt);

	always_comb
	begin
		pred_d        = '0;
		pred_d[P_EQ]  = eq;
		pred_d[P_LT]  = lt & !unordered;
		pred_d[P_LE]  = (lt | eq) & !unordered;
		pred_d[P_MLT] = mag_lt;
		pred_d[P_UN]  = unordered;
		// unordered pairs count as not equal
		pred_d[P_NE]  = !eq;
		pred_d[P_GE]  = !lt & !unordered;
		pred_d[P_GT]  = !(lt | eq) & !unordered;
		pred_d[P_MGE] = !mag_lt;
		pred_d[P_OR]  = !unordered;
	end

	// exception flags, two infinities also raise nan
	assign nan_d  = nan_a | nan_b | (inf_a & inf_b);
	assign snan_d = snan_a | snan_b;

	// ====================================================================
	// output register
	// ====================================================================

	// free slot, or the held result leaves this cycle
	assign in_ready = !valid_q | out_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			valid_q <= 1'b0;
		else if (in_valid && in_ready)
			valid_q <= 1'b1;
		else if (out_ready)
			valid_q <= 1'b0;
	end

	// payload only loads on accept
	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
		begin
			pred_q <= pred_d;
			nan_q  <= nan_d;
			snan_q <= snan_d;
		end
	end

	assign out_valid = valid_q;
	assign pred      = pred_q;
	assign nan       = nan_q;
	assign snan      = snan_q;

endmodule

//--- src/fcmp_dispatch.sv
// round-robin request distributor
// one lane under the write pointer sees the request at a time
module fcmp_dispatch
(
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                in_valid,
	output logic                                in_ready,
	input  fp128_pkg::fp128_t                   a,
	input  fp128_pkg::fp128_t                   b,
	output logic [fcmp_pkg::NUM_LANES-1:0]      lane_in_valid,
	input  logic [fcmp_pkg::NUM_LANES-1:0]      lane_in_ready,
	output fp128_pkg::fp128_t                   lane_a,
	output fp128_pkg::fp128_t                   lane_b
);

	import fcmp_pkg::*;

	// lane that takes the next request
	logic [LANE_W-1:0] wr_ptr;
	// request transfer this cycle
	logic              accept;

	// operands go to every lane, only one lane sees valid
	assign lane_a = a;
	assign lane_b = b;

	// ====================================================================
	// routing
	// ====================================================================

	always_comb
	begin
		lane_in_valid         = '0;
		lane_in_valid[wr_ptr] = in_valid;
	end

	// upstream sees only the selected lane
	assign in_ready = lane_in_ready[wr_ptr];
	assign accept   = in_valid & in_ready;

	// ====================================================================
	// write pointer
	// ====================================================================

	// explicit wrap, so lane counts below the pointer range are safe
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			wr_ptr <= '0;
		else if (accept)
		begin
			if (wr_ptr == LANE_W'(NUM_LANES - 1))
				wr_ptr <= '0;
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

endmodule

//--- src/fcmp_collect.sv
// in-order result drain
// follows the dispatcher's order with its own read pointer
module fcmp_collect
(
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [fcmp_pkg::NUM_LANES-1:0]      lane_out_valid,
	output logic [fcmp_pkg::NUM_LANES-1:0]      lane_out_ready,
	input  fcmp_pkg::fcmp_pred_t                lane_pred [fcmp_pkg::NUM_LANES],
	input  logic [fcmp_pkg::NUM_LANES-1:0]      lane_nan,
	input  logic [fcmp_pkg::NUM_LANES-1:0]      lane_snan,
	output logic                                out_valid,
	input  logic                                out_ready,
	output fcmp_pkg::fcmp_pred_t                pred,
	output logic                                nan,
	output logic                                snan
);

	import fcmp_pkg::*;

	// lane holding the oldest outstanding result
	logic [LANE_W-1:0] rd_ptr;
	// result transfer this cycle
	logic              drain;

	// ====================================================================
	// result select
	// ====================================================================

	// a later lane may already be full, it waits its turn
	assign out_valid = lane_out_valid[rd_ptr];
	assign pred      = lane_pred[rd_ptr];
	assign nan       = lane_nan[rd_ptr];
	assign snan      = lane_snan[rd_ptr];

	// only the selected lane is released
	always_comb
	begin
		lane_out_ready         = '0;
		lane_out_ready[rd_ptr] = out_ready;
	end

	assign drain = out_valid & out_ready;

	// ====================================================================
	// read pointer
	// ====================================================================

	// same wrap rule as the write pointer
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_ptr <= '0;
		else if (drain)
		begin
			if (rd_ptr == LANE_W'(NUM_LANES - 1))
				rd_ptr <= '0;
			else
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

//--- src/fcmp_unit_top.sv
// quad precision compare unit
// dispatcher, NUM_LANES registered lanes, in-order collector
module fcmp_unit_top
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  fp128_pkg::fp128_t      a,
	input  fp128_pkg::fp128_t      b,
	output logic                   out_valid,
	input  logic                   out_ready,
	output fcmp_pkg::fcmp_pred_t   pred,
	output logic                   nan,
	output logic                   snan
);

	import fp128_pkg::*;
	import fcmp_pkg::*;

	// dispatcher to lanes
	logic [NUM_LANES-1:0]   lane_in_valid;
	logic [NUM_LANES-1:0]   lane_in_ready;
	fp128_t                 lane_a;
	fp128_t                 lane_b;

	// lanes to collector
	logic [NUM_LANES-1:0]   lane_out_valid;
	logic [NUM_LANES-1:0]   lane_out_ready;
	fcmp_pred_t             lane_pred [NUM_LANES];
	logic [NUM_LANES-1:0]   lane_nan;
	logic [NUM_LANES-1:0]   lane_snan;

	fcmp_dispatch u_dispatch (.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
		.in_ready(in_ready), .a(a), .b(b), .lane_in_valid(lane_in_valid),
		.lane_in_ready(lane_in_ready), .lane_a(lane_a), .lane_b(lane_b));

	// identical lanes, each with its own output slot
	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_lane
		fcmp_lane u_lane (.clk(clk), .rst_n(rst_n), .in_valid(lane_in_valid[g]),
			.in_ready(lane_in_ready[g]), .a(lane_a), .b(lane_b),
			.out_valid(lane_out_valid[g]), .out_ready(lane_out_ready[g]),
			.pred(lane_pred[g]), .nan(lane_nan[g]), .snan(lane_snan[g]));
	end

	fcmp_collect u_collect (.clk(clk), .rst_n(rst_n), .lane_out_valid(lane_out_valid),
		.lane_out_ready(lane_out_ready), .lane_pred(lane_pred), .lane_nan(lane_nan),
		.lane_snan(lane_snan), .out_valid(out_valid), .out_ready(out_ready),
		.pred(pred), .nan(nan), .snan(snan));

endmodule

//--- dv/fcmp_tb.sv
// testbench for the quad precision compare unit
// requests and expected results come from the golden file
module fcmp_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import fp128_pkg::*;
	import fcmp_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int MAX_REQ    = 64;
	// a, b, pred, nan, snan
	localparam int COLS       = 5;

	logic         clk = 1'b0;
	logic         rst_n;
	logic         in_valid;
	logic         in_ready;
	fp128_t       a;
	fp128_t       b;
	logic         out_valid;
	logic         out_ready;
	fcmp_pred_t   pred;
	logic         nan;
	logic         snan;

	// golden data with one word per column
	logic [127:0] golden_mem [0:COLS*MAX_REQ-1];
	fp128_t       req_a [MAX_REQ];
	fp128_t       req_b [MAX_REQ];
	fcmp_pred_t   exp_pred_q [$];
	logic         exp_nan_q [$];
	logic         exp_snan_q [$];

	int           n_req;
	int           rx_count = 0;
	int           accepted = 0;
	logic         hold;
	logic         start;
	logic         loaded;

	fcmp_unit_top dut (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
		.a(a), .b(b), .out_valid(out_valid), .out_ready(out_ready), .pred(pred),
		.nan(nan), .snan(snan));

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ========================================================================
	// checks
	// ========================================================================

	task automatic stop_run();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_pred(input string name, input fcmp_pred_t expected,
		input fcmp_pred_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected %b actual %b", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
			stop_run();
		end
	endtask

	// marker for words the file did not overwrite
	// the pattern differs per address
	function automatic logic [127:0] unfilled_word(input int idx);
		return ~128'(idx);
	endfunction

	task automatic load_golden();
		for (int k = 0; k < COLS * MAX_REQ; k++)
			golden_mem[k] = unfilled_word(k);
		$readmemh("dv/fcmp_golden.txt", golden_mem);
		n_req = 0;
		while (n_req < MAX_REQ && golden_mem[COLS*n_req] != unfilled_word(COLS*n_req))
			n_req++;
		// the stall test needs every lane filled plus one waiting
		if (n_req <= NUM_LANES)
		begin
			$display("golden file holds too few requests");
			stop_run();
		end
		for (int i = 0; i < n_req; i++)
		begin
			req_a[i] = golden_mem[COLS*i];
			req_b[i] = golden_mem[COLS*i+1];
			exp_pred_q.push_back(golden_mem[COLS*i+2][15:0]);
			exp_nan_q.push_back(golden_mem[COLS*i+3][0]);
			exp_snan_q.push_back(golden_mem[COLS*i+4][0]);
		end
	endtask

	// ========================================================================
	// stimulus
	// ========================================================================

	// request driver holds valid until the transfer edge
	initial
	begin
		logic done;
		in_valid = 1'b0;
		a = '0;
		b = '0;
		wait (start);
		for (int i = 0; i < n_req; i++)
		begin
			in_valid = 1'b1;
			a = req_a[i];
			b = req_b[i];
			done = 1'b0;
			while (!done)
			begin
				@(posedge clk);
				done = in_ready;
				@(negedge clk);
			end
		end
		in_valid = 1'b0;
	end

	// back-pressure with out_ready high about three cycles in four
	initial
	begin
		integer seed;
		seed = 12;
		out_ready = 1'b0;
		forever
		begin
			@(negedge clk);
			if (hold)
				out_ready = 1'b0;
			else
				out_ready = (($random(seed) & 32'h3) != 0);
		end
	end

	always @(posedge clk)
	begin
		if (rst_n && in_valid && in_ready)
			accepted++;
	end

	// result monitor pops expected values in request order
	always @(posedge clk)
	begin
		if (rst_n && out_valid && out_ready)
		begin
			if (exp_pred_q.size() == 0)
			begin
				$display("a result arrived with no request outstanding");
				stop_run();
			end
			check_pred($sformatf("req %0d pred", rx_count), exp_pred_q.pop_front(), pred);
			check_flag($sformatf("req %0d nan", rx_count), exp_nan_q.pop_front(), nan);
			check_flag($sformatf("req %0d snan", rx_count), exp_snan_q.pop_front(), snan);
			rx_count++;
		end
	end

	initial
	begin
		wait (loaded);
		#((n_req * 20 + 50) * CLK_PERIOD);
		$display("timeout: results did not all arrive");
		stop_run();
	end

	initial
	begin
		rst_n = 1'b0;
		hold = 1'b1;
		start = 1'b0;
		loaded = 1'b0;
		load_golden();
		loaded = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_flag("out_valid after reset", 1'b0, out_valid);
		check_flag("in_ready after reset", 1'b1, in_ready);
		// with the output stalled only one request per lane gets in
		start = 1'b1;
		repeat (NUM_LANES + 4) @(negedge clk);
		check_count("requests accepted under stall", NUM_LANES, accepted);
		check_flag("in_ready under stall", 1'b0, in_ready);
		check_flag("out_valid under stall", 1'b1, out_valid);
		hold = 1'b0;
		wait (accepted == n_req);
		// the oldest result sits under the read pointer until the lanes are empty
		@(negedge clk);
		while (out_valid)
			@(negedge clk);
		// idle a little longer to catch duplicated results
		repeat (NUM_LANES + 2) @(negedge clk);
		check_count("results received", n_req, rx_count);
		$display("All tests passed");
		$finish;
	end

endmodule

//--- dv/fcmp_golden.txt
// one request per line, all values hex
// a, b, expected predicate word, nan, snan
// ordered, mixed signs and magnitudes
3fff0000000000000000000000000000 40000000000000000000000000000000 110e 0 0
40000000000000000000000000000000 3fff0000000000000000000000000000 1f00 0 0
3fff0000000000000000000000000000 3fff0000000000000000000000000000 1a05 0 0
3fff0000000000000000000000000000 3fff8000000000000000000000000000 110e 0 0
40000000000000000000000000000000 3fff8000000000000000000000000000 1f00 0 0
bfff0000000000000000000000000000 3fff0000000000000000000000000000 1906 0 0
3fff0000000000000000000000000000 bfff0000000000000000000000000000 1f00 0 0
c0000000000000000000000000000000 bfff0000000000000000000000000000 1906 0 0
bfff0000000000000000000000000000 c0000000000000000000000000000000 1708 0 0
c0000000000000000000000000000000 3fff0000000000000000000000000000 1906 0 0
3fff0000000000000000000000000000 c0000000000000000000000000000000 1708 0 0
bfff0000000000000000000000000000 bfff0000000000000000000000000000 1a05 0 0
// zeros and a denormal
00000000000000000000000000000000 80000000000000000000000000000000 1a05 0 0
80000000000000000000000000000000 00000000000000000000000000000000 1a05 0 0
00000000000000000000000000000000 00000000000000000000000000000000 1a05 0 0
80000000000000000000000000000000 3fff0000000000000000000000000000 110e 0 0
00000000000000000000000000000000 00000000000000000000000000000001 110e 0 0
80000000000000000000000000000000 00000000000000000000000000000001 110e 0 0
// infinities
7fff0000000000000000000000000000 40000000000000000000000000000000 1f00 0 0
ffff0000000000000000000000000000 c0000000000000000000000000000000 1906 0 0
ffff0000000000000000000000000000 7fff0000000000000000000000000000 1906 1 0
7fff0000000000000000000000000000 7fff0000000000000000000000000000 1a05 1 0
// quiet and signaling NaN
7fff8000000000000000000000000000 3fff0000000000000000000000000000 0910 1 0
3fff0000000000000000000000000000 7fff8000000000000000000000000000 0118 1 0
7fff8000000000000000000000000000 7fff8000000000000000000000000000 0910 1 0
7fff0000000000000000000000000001 3fff0000000000000000000000000000 0910 1 1
3fff0000000000000000000000000000 7fff0000000000000000000000000001 0118 1 1
7fff0000000000000000000000000001 7fff8000000000000000000000000000 0118 1 1

//--- run_sim.sh
#!/bin/sh
# build and run the compare unit testbench with Verilator
# run from anywhere, paths are relative to the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f project.f \
	--top-module fcmp_tb -Mdir "$BUILD_DIR" -o fcmp_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/fcmp_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- project.f
src/fp128_pkg.sv
src/fcmp_pkg.sv
src/fp128_decomp.sv
src/fcmp_lane.sv
src/fcmp_dispatch.sv
src/fcmp_collect.sv
src/fcmp_unit_top.sv
dv/fcmp_tb.sv
